//--- verilog.f
verilog/mif_pkg.sv
verilog/mif_wr_channel.sv
verilog/mif_rd_channel.sv
verilog/mif_cmd_arbiter.sv
verilog/memif.sv
verif/tb_mcb_model.sv
verif/tb_memif.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memif testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_memif \
    -f verilog.f -o sim_memif > sim.log 2>&1 \
    && ./obj_dir/sim_memif >> sim.log 2>&1 \
    || echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

//--- verif/tb_memif.sv
`default_nettype none
`timescale 1ns/100ps

module tb_memif import mif_pkg::*; ();

    localparam int unsigned FRAME = 1024;
    localparam int WORDS = 64;
    localparam int BURSTS = 4;
    localparam int NUM_ROWS = 4;
    localparam int CYCLES_PER_FRAME = 2000;

    logic       clk_mif;
    logic       sys_rst;
    logic       vsync;
    pix_word_t  pix_write;
    logic       pix_write_valid;
    logic       pix_write_ready;
    pix_word_t  pix_read;
    logic       pix_read_valid;
    logic       pix_read_ready;
    logic       mcb_cmd_en;
    mcb_cmd_t   mcb_cmd;
    burst_len_t mcb_cmd_bl;
    logic       mcb_cmd_full;
    logic       mcb_wr_en;
    pix_word_t  mcb_wr_data;
    logic       mcb_wr_full;
    logic       mcb_rd_en;
    pix_word_t  mcb_rd_data;
    logic       mcb_rd_empty;
    logic       force_cmd_full;
    logic       force_wr_full;
    logic       model_idle;

    ////////////////////////////////////////////////////////////
    // Test table with duties out of 16
    ////////////////////////////////////////////////////////////

    int   row_ready_duty  [NUM_ROWS] = '{16, 10, 14, 6};
    int   row_valid_duty  [NUM_ROWS] = '{16, 12, 6, 9};
    logic row_wr_full_en  [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    logic row_cmd_full_en [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1};
    int   row_frames      [NUM_ROWS] = '{2, 1, 1, 2};

    // Current row
    int   ready_duty;
    int   valid_duty;
    logic wr_full_en;
    logic cmd_full_en;
    logic frame_active;

    // Frame bookkeeping
    pix_word_t ref_mem [WORDS];
    pix_word_t frame_words [WORDS];
    int        acc_count;
    int        rd_words;
    int        rd_cmds;
    int        wr_cmds;
    logic      prev_accept;
    pix_word_t prev_word;
    logic      prev_cmd_en;
    logic      prev_cmd_full;
    int        value_errors;
    int        protocol_errors;

    logic [16:0] lfsr = 17'd70250;

    memif #(
        .FRAME_BYTES (FRAME)
    ) i_dut (
        .clk_mif         (clk_mif),
        .sys_rst         (sys_rst),
        .vsync           (vsync),
        .pix_write       (pix_write),
        .pix_write_valid (pix_write_valid),
        .pix_write_ready (pix_write_ready),
        .pix_read        (pix_read),
        .pix_read_valid  (pix_read_valid),
        .pix_read_ready  (pix_read_ready),
        .mcb_cmd_en      (mcb_cmd_en),
        .mcb_cmd         (mcb_cmd),
        .mcb_cmd_bl      (mcb_cmd_bl),
        .mcb_cmd_full    (mcb_cmd_full),
        .mcb_wr_en       (mcb_wr_en),
        .mcb_wr_data     (mcb_wr_data),
        .mcb_wr_full     (mcb_wr_full),
        .mcb_rd_en       (mcb_rd_en),
        .mcb_rd_data     (mcb_rd_data),
        .mcb_rd_empty    (mcb_rd_empty)
    );

    tb_mcb_model i_model (
        .clk_mif        (clk_mif),
        .cmd_en         (mcb_cmd_en),
        .cmd            (mcb_cmd),
        .cmd_full       (mcb_cmd_full),
        .force_cmd_full (force_cmd_full),
        .wr_en          (mcb_wr_en),
        .wr_data        (mcb_wr_data),
        .wr_full        (mcb_wr_full),
        .force_wr_full  (force_wr_full),
        .rd_en          (mcb_rd_en),
        .rd_data        (mcb_rd_data),
        .rd_empty       (mcb_rd_empty),
        .idle           (model_idle)
    );

    initial begin
        clk_mif = 1'b0;
        forever #4 clk_mif = ~clk_mif;
    end

    // Fibonacci LFSR x^17 + x^14 + 1 stepped once per bit
    function automatic int unsigned take_bits(int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[16] ^ lfsr[13];
            lfsr = {lfsr[15:0], fb};
            v    = (v << 1) | 32'(fb);
        end
        return v;
    endfunction

    function automatic pix_word_t rand_word();
        pix_word_t w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            w = {w[95:0], take_bits(32)};
        end
        return w;
    endfunction

    // Memory content before any write
    function automatic pix_word_t preload_word(int unsigned a);
        return {32'hc0de0000 ^ a, ~a, a * 32'h9e3779b1, a + 32'h1234};
    endfunction

    task automatic report_value(string name, pix_word_t got, pix_word_t exp);
        $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic report_protocol(string msg);
        $display("Error at %0d ns: %s", $time, msg);
        protocol_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus 1 ns after the rising edge
    ////////////////////////////////////////////////////////////

    initial begin
        int unsigned valid_bits;
        forever begin
            @(posedge clk_mif);
            #1;
            pix_read_ready  = take_bits(4) < ready_duty;
            force_wr_full   = wr_full_en && (take_bits(2) == 0);
            force_cmd_full  = cmd_full_en && (take_bits(2) == 0);
            // LFSR steps do not depend on the frame flags
            valid_bits      = take_bits(4);
            pix_write_valid = frame_active && (acc_count < WORDS) && (valid_bits < valid_duty);
            pix_write       = rand_word();
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks at the falling edge
    ////////////////////////////////////////////////////////////

    task automatic check_command();
        assert (!prev_cmd_en) else report_protocol("commands in adjacent cycles");
        assert (!prev_cmd_full) else report_protocol("command issued after mcb_cmd_full");
        assert (frame_active) else report_protocol("command outside a frame");
        assert (mcb_cmd_bl == burst_len_t'(BURST_LENGTH - 1))
            else report_value("mcb_cmd_bl", 128'(mcb_cmd_bl), 128'(BURST_LENGTH - 1));
        assert (mcb_cmd.instr inside {MCB_READ, MCB_WRITE})
            else report_protocol("unknown command code");
        if (mcb_cmd.instr == MCB_READ) begin
            assert (rd_cmds < BURSTS)
                else report_protocol("read command after the last burst");
            if (rd_cmds < BURSTS) begin
                assert (mcb_cmd.byte_addr == byte_addr_t'(rd_cmds * BYTE_PER_CMD))
                    else report_value("mcb_cmd.byte_addr", 128'(mcb_cmd.byte_addr),
                                      128'(rd_cmds * BYTE_PER_CMD));
            end
            rd_cmds++;
        end else if (mcb_cmd.instr == MCB_WRITE) begin
            // Burst must already have been read
            assert (wr_cmds < rd_cmds) else report_protocol("write ahead of the read stream");
            assert (wr_cmds < BURSTS)
                else report_protocol("write command after the last burst");
            if (wr_cmds < BURSTS) begin
                assert (mcb_cmd.byte_addr == byte_addr_t'(wr_cmds * BYTE_PER_CMD))
                    else report_value("mcb_cmd.byte_addr", 128'(mcb_cmd.byte_addr),
                                      128'(wr_cmds * BYTE_PER_CMD));
            end
            wr_cmds++;
        end
    endtask

    always @(negedge clk_mif) begin
        logic word_offered;
        if (sys_rst) begin
            assert (!mcb_cmd_en && !mcb_wr_en && !pix_read_valid)
                else report_protocol("output active during reset");
        end else begin
            // Push exactly one cycle after acceptance
            assert (mcb_wr_en == prev_accept)
                else report_value("mcb_wr_en", 128'(mcb_wr_en), 128'(prev_accept));
            if (prev_accept) begin
                assert (mcb_wr_data == prev_word)
                    else report_value("mcb_wr_data", mcb_wr_data, prev_word);
            end
            assert (!(force_wr_full && pix_write_ready))
                else report_protocol("pix_write_ready high while the write FIFO is full");
            assert (!(pix_read_valid && !pix_read_ready))
                else report_protocol("pix_read_valid high without pix_read_ready");
            // Sink takes the FIFO head whenever it is ready and a word waits
            word_offered = !mcb_rd_empty && pix_read_ready;
            assert (mcb_rd_en == word_offered)
                else report_value("mcb_rd_en", 128'(mcb_rd_en), 128'(word_offered));
            if (pix_write_valid && pix_write_ready) begin
                assert (acc_count < WORDS)
                    else report_protocol("pixel word accepted beyond the frame");
                if (acc_count < WORDS) begin
                    frame_words[6'(acc_count)] = pix_write;
                end
                acc_count++;
            end
            if (pix_read_valid) begin
                assert (rd_words < WORDS)
                    else report_protocol("read data beyond the frame end");
                if (rd_words < WORDS) begin
                    assert (pix_read == ref_mem[6'(rd_words)])
                        else report_value("pix_read", pix_read, ref_mem[6'(rd_words)]);
                end
                rd_words++;
            end
            if (mcb_cmd_en) begin
                check_command();
            end
            prev_accept   = pix_write_valid && pix_write_ready;
            prev_word     = pix_write;
            prev_cmd_en   = mcb_cmd_en;
            prev_cmd_full = mcb_cmd_full;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame sequence
    ////////////////////////////////////////////////////////////

    task automatic run_frame();
        @(posedge clk_mif);
        #1;
        acc_count    = 0;
        rd_words     = 0;
        rd_cmds      = 0;
        wr_cmds      = 0;
        frame_active = 1'b1;
        vsync        = 1'b1;
        @(posedge clk_mif);
        #1;
        vsync = 1'b0;
        wait (rd_cmds == BURSTS && wr_cmds == BURSTS && rd_words == WORDS);
        // Model must have taken the last write burst
        @(posedge clk_mif);
        #1;
        wait (model_idle);
        // Quiet gap with no command expected
        repeat (20) @(posedge clk_mif);
        for (int k = 0; k < WORDS; k++) begin
            assert (i_model.mem[6'(k)] == frame_words[6'(k)])
                else report_value("i_model.mem", i_model.mem[6'(k)], frame_words[6'(k)]);
            ref_mem[6'(k)] = frame_words[6'(k)];
        end
        frame_active = 1'b0;
    endtask

    initial begin
        sys_rst         = 1'b1;
        vsync           = 1'b0;
        pix_write       = '0;
        pix_write_valid = 1'b0;
        pix_read_ready  = 1'b0;
        force_cmd_full  = 1'b0;
        force_wr_full   = 1'b0;
        ready_duty      = 0;
        valid_duty      = 0;
        wr_full_en      = 1'b0;
        cmd_full_en     = 1'b0;
        frame_active    = 1'b0;
        acc_count       = WORDS;
        rd_words        = 0;
        rd_cmds         = 0;
        wr_cmds         = 0;
        prev_accept     = 1'b0;
        prev_word       = '0;
        prev_cmd_en     = 1'b0;
        prev_cmd_full   = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        for (int k = 0; k < WORDS; k++) begin
            ref_mem[6'(k)] = preload_word(k * BYTE_PER_WORD);
        end
        repeat (4) @(posedge clk_mif);
        #1;
        sys_rst = 1'b0;
        // Idle before the first vsync
        repeat (10) @(posedge clk_mif);
        for (int r = 0; r < NUM_ROWS; r++) begin
            ready_duty  = row_ready_duty[r];
            valid_duty  = row_valid_duty[r];
            wr_full_en  = row_wr_full_en[r];
            cmd_full_en = row_cmd_full_en[r];
            for (int f = 0; f < row_frames[r]; f++) begin
                run_frame();
            end
        end
        $display("Errors: %0d value mismatches, %0d protocol violations",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog budget scales with the frames in the table
    initial begin
        int total_frames;
        total_frames = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_frames += row_frames[r];
        end
        #(total_frames * CYCLES_PER_FRAME * 8 + 200);
        $display("Watchdog expired before all frames finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_mcb_model.sv
`default_nettype none
`timescale 1ns/100ps

module tb_mcb_model import mif_pkg::*; (
    input  logic      clk_mif,
    // Command FIFO
    input  logic      cmd_en,
    input  mcb_cmd_t  cmd,
    output logic      cmd_full,
    input  logic      force_cmd_full,
    // Write FIFO
    input  logic      wr_en,
    input  pix_word_t wr_data,
    output logic      wr_full,
    input  logic      force_wr_full,
    // Read FIFO
    input  logic      rd_en,
    output pix_word_t rd_data,
    output logic      rd_empty,
    // No command waiting
    output logic      idle
);

    // 1024-byte frame, 64 words
    localparam int MEM_WORDS = 64;
    localparam int CMD_DELAY = 3;

    pix_word_t mem [MEM_WORDS];
    mcb_cmd_t  cmd_q [$];
    pix_word_t wr_q [$];
    pix_word_t rd_q [$];
    int        cmd_wait;

    // FIFOs never fill on their own, only when the testbench asks
    assign cmd_full = force_cmd_full;
    assign wr_full  = force_wr_full;

    // Start pattern, every bit of the byte address has an effect
    function automatic pix_word_t fill_word(int unsigned a);
        return {32'hc0de0000 ^ a, ~a, a * 32'h9e3779b1, a + 32'h1234};
    endfunction

    initial begin
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[6'(k)] = fill_word(k * BYTE_PER_WORD);
        end
        cmd_wait = 0;
        rd_empty = 1'b1;
        rd_data  = '0;
        idle     = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Port 0 behaviour
    ////////////////////////////////////////////////////////////

    always @(posedge clk_mif) begin
        int unsigned base;
        mcb_cmd_t    head;
        if (rd_en) begin
            void'(rd_q.pop_front());
        end
        if (cmd_en) begin
            cmd_q.push_back(cmd);
        end
        if (wr_en) begin
            wr_q.push_back(wr_data);
        end
        // Commands run in order, each after a short latency
        if (cmd_q.size() != 0) begin
            head = cmd_q[0];
            base = head.byte_addr / BYTE_PER_WORD;
            if (cmd_wait < CMD_DELAY) begin
                cmd_wait++;
            end else if (head.instr == MCB_READ) begin
                for (int i = 0; i < BURST_LENGTH; i++) begin
                    rd_q.push_back(mem[6'(base + i)]);
                end
                void'(cmd_q.pop_front());
                cmd_wait = 0;
            end else if (wr_q.size() >= BURST_LENGTH) begin
                // Write waits for its whole burst of data
                for (int i = 0; i < BURST_LENGTH; i++) begin
                    mem[6'(base + i)] = wr_q.pop_front();
                end
                void'(cmd_q.pop_front());
                cmd_wait = 0;
            end
        end
        // Outputs show the state after this edge
        rd_empty <= (rd_q.size() == 0);
        rd_data  <= (rd_q.size() != 0) ? rd_q[0] : '0;
        idle     <= (cmd_q.size() == 0);
    end

endmodule

`default_nettype wire

//--- verilog/memif.sv
`default_nettype none
`timescale 1ns/100ps

module memif import mif_pkg::*; #(
    // Whole number of bursts
    parameter int unsigned FRAME_BYTES = UXGA_FRAME_BYTES
) (
    input  logic       clk_mif,
    input  logic       sys_rst,
    input  logic       vsync,
    // Pixel input
    input  pix_word_t  pix_write,
    input  logic       pix_write_valid,
    output logic       pix_write_ready,
    // Pixel output
    output pix_word_t  pix_read,
    output logic       pix_read_valid,
    input  logic       pix_read_ready,
    // Controller port 0 command
    output logic       mcb_cmd_en,
    output mcb_cmd_t   mcb_cmd,
    output burst_len_t mcb_cmd_bl,
    input  logic       mcb_cmd_full,
    // Controller port 0 write data
    output logic       mcb_wr_en,
    output pix_word_t  mcb_wr_data,
    input  logic       mcb_wr_full,
    // Controller port 0 read data
    output logic       mcb_rd_en,
    input  pix_word_t  mcb_rd_data,
    input  logic       mcb_rd_empty
);

    issue_req_t wr_req;
    issue_req_t rd_req;
    logic       wr_done;
    logic       rd_done;

    // Every command moves a fixed burst
    assign mcb_cmd_bl = burst_len_t'(BURST_LENGTH - 1);

    ////////////////////////////////////////////////////////////
    // Frame writer, reader and the shared command port
    ////////////////////////////////////////////////////////////

    mif_wr_channel #(
        .FRAME_BYTES (FRAME_BYTES)
    ) i_wr_channel (
        .clk_mif         (clk_mif),
        .sys_rst         (sys_rst),
        .vsync           (vsync),
        .pix_write       (pix_write),
        .pix_write_valid (pix_write_valid),
        .pix_write_ready (pix_write_ready),
        .mcb_wr_en       (mcb_wr_en),
        .mcb_wr_data     (mcb_wr_data),
        .mcb_wr_full     (mcb_wr_full),
        .wr_req          (wr_req),
        .wr_done         (wr_done)
    );

    mif_rd_channel #(
        .FRAME_BYTES (FRAME_BYTES)
    ) i_rd_channel (
        .clk_mif        (clk_mif),
        .sys_rst        (sys_rst),
        .vsync          (vsync),
        .pix_read       (pix_read),
        .pix_read_valid (pix_read_valid),
        .pix_read_ready (pix_read_ready),
        .mcb_rd_en      (mcb_rd_en),
        .mcb_rd_data    (mcb_rd_data),
        .mcb_rd_empty   (mcb_rd_empty),
        .rd_req         (rd_req),
        .rd_done        (rd_done)
    );

    mif_cmd_arbiter i_cmd_arbiter (
        .clk_mif      (clk_mif),
        .sys_rst      (sys_rst),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .rd_done      (rd_done),
        .wr_done      (wr_done),
        .mcb_cmd_en   (mcb_cmd_en),
        .mcb_cmd      (mcb_cmd),
        .mcb_cmd_full (mcb_cmd_full)
    );

endmodule

`default_nettype wire

//--- verilog/mif_cmd_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module mif_cmd_arbiter import mif_pkg::*; (
    input  logic       clk_mif,
    input  logic       sys_rst,
    // Channel requests and their acknowledges
    input  issue_req_t rd_req,
    input  issue_req_t wr_req,
    output logic       rd_done,
    output logic       wr_done,
    // Controller command port
    output logic       mcb_cmd_en,
    output mcb_cmd_t   mcb_cmd,
    input  logic       mcb_cmd_full
);

    issue_state_t issue_state;
    logic         rd_win;
    logic         wr_win;

    ////////////////////////////////////////////////////////////
    // Selection
    ////////////////////////////////////////////////////////////

    // Reads always first
    assign rd_win = !mcb_cmd_full && rd_req.req;

    // Write only behind the reader, unread frame data stays intact
    assign wr_win = !mcb_cmd_full && !rd_req.req && wr_req.req
                    && (wr_req.byte_addr < rd_req.byte_addr);

    ////////////////////////////////////////////////////////////
    // Issue FSM, at most one command every second cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            issue_state <= ISSUE_WAIT;
            mcb_cmd_en  <= 1'b0;
            rd_done     <= 1'b0;
            wr_done     <= 1'b0;
        end else begin
            case (issue_state)
                ISSUE_WAIT: begin
                    if (rd_win || wr_win) begin
                        mcb_cmd_en  <= 1'b1;
                        issue_state <= ISSUE_ACT;
                    end
                    rd_done <= rd_win;
                    wr_done <= wr_win;
                end
                ISSUE_ACT: begin
                    // Strobes last exactly one cycle
                    mcb_cmd_en  <= 1'b0;
                    rd_done     <= 1'b0;
                    wr_done     <= 1'b0;
                    issue_state <= ISSUE_WAIT;
                end
                default: issue_state <= ISSUE_WAIT;
            endcase
        end
    end

    // Command word, only looked at while mcb_cmd_en is high
    always_ff @(posedge clk_mif) begin
        if (issue_state == ISSUE_WAIT) begin
            if (rd_win) begin
                mcb_cmd <= '{instr: MCB_READ, byte_addr: rd_req.byte_addr};
            end else if (wr_win) begin
                mcb_cmd <= '{instr: MCB_WRITE, byte_addr: wr_req.byte_addr};
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mif_rd_channel.sv
`default_nettype none
`timescale 1ns/100ps

module mif_rd_channel import mif_pkg::*; #(
    parameter int unsigned FRAME_BYTES = UXGA_FRAME_BYTES
) (
    input  logic       clk_mif,
    input  logic       sys_rst,
    input  logic       vsync,
    // Outgoing pixel stream
    output pix_word_t  pix_read,
    output logic       pix_read_valid,
    input  logic       pix_read_ready,
    // Controller read FIFO
    output logic       mcb_rd_en,
    input  pix_word_t  mcb_rd_data,
    input  logic       mcb_rd_empty,
    // Burst request to the arbiter
    output issue_req_t rd_req,
    input  logic       rd_done
);

    rd_state_t  rd_state;
    byte_addr_t rd_addr;

    // Pop and present in the same cycle, FIFO head is already valid
    assign mcb_rd_en      = !mcb_rd_empty && pix_read_ready;
    assign pix_read_valid = !mcb_rd_empty && pix_read_ready;
    assign pix_read       = mcb_rd_data;

    ////////////////////////////////////////////////////////////
    // Burst FSM
    ////////////////////////////////////////////////////////////

    // One burst in flight at a time
    // The next read goes out once the previous one has drained to the sink
    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            rd_state <= RD_IDLE;
            rd_addr  <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (vsync) begin
                        rd_addr  <= '0;
                        rd_state <= RD_WAIT_DRAIN;
                    end
                end
                RD_WAIT_DATA: begin
                    // First word of the burst has landed
                    if (!mcb_rd_empty) begin
                        rd_state <= RD_WAIT_DRAIN;
                    end
                end
                RD_WAIT_DRAIN: begin
                    // Sink still taking data, FIFO fully drained
                    if (pix_read_ready && mcb_rd_empty) begin
                        rd_state <= RD_ISSUE;
                    end
                end
                RD_ISSUE: begin
                    if (rd_done) begin
                        // After the last burst the address rests at the frame end,
                        // which lets the writer finish the frame
                        rd_addr <= rd_addr + byte_addr_t'(BYTE_PER_CMD);
                        if (rd_addr == byte_addr_t'(FRAME_BYTES - BYTE_PER_CMD)) begin
                            rd_state <= RD_IDLE;
                        end else begin
                            rd_state <= RD_WAIT_DATA;
                        end
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    assign rd_req = '{req: (rd_state == RD_ISSUE), byte_addr: rd_addr};

endmodule

`default_nettype wire

//--- verilog/mif_wr_channel.sv
`default_nettype none
`timescale 1ns/100ps

module mif_wr_channel import mif_pkg::*; #(
    parameter int unsigned FRAME_BYTES = UXGA_FRAME_BYTES
) (
    input  logic       clk_mif,
    input  logic       sys_rst,
    input  logic       vsync,
    // Incoming pixel stream
    input  pix_word_t  pix_write,
    input  logic       pix_write_valid,
    output logic       pix_write_ready,
    // Controller write FIFO
    output logic       mcb_wr_en,
    output pix_word_t  mcb_wr_data,
    input  logic       mcb_wr_full,
    // Burst request to the arbiter
    output issue_req_t wr_req,
    input  logic       wr_done
);

    wr_state_t  wr_state;
    byte_addr_t wr_addr;
    burst_cnt_t wr_count;
    logic       burst_take;

    // Accept only while a frame is being stored and the FIFO has room
    assign pix_write_ready = pix_write_valid && !mcb_wr_full && (wr_state != WR_IDLE);

    // A full burst sits in the FIFO and is handed to the arbiter
    assign burst_take = (wr_state == WR_PUSH) && (wr_count >= burst_cnt_t'(BURST_LENGTH));

    ////////////////////////////////////////////////////////////
    // Write FIFO push, one cycle behind acceptance
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            mcb_wr_en <= 1'b0;
        end else begin
            mcb_wr_en <= pix_write_ready;
        end
    end

    // Data word follows the enable
    always_ff @(posedge clk_mif) begin
        mcb_wr_data <= pix_write;
    end

    // Words in the FIFO not yet claimed by a command
    // Leftovers carry into the next frame, keeping acceptance order
    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            wr_count <= '0;
        end else if (burst_take) begin
            wr_count <= wr_count + burst_cnt_t'(mcb_wr_en) - burst_cnt_t'(BURST_LENGTH);
        end else begin
            wr_count <= wr_count + burst_cnt_t'(mcb_wr_en);
        end
    end

    ////////////////////////////////////////////////////////////
    // Burst FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            wr_state <= WR_IDLE;
            wr_addr  <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (vsync) begin
                        wr_addr  <= '0;
                        wr_state <= WR_PUSH;
                    end
                end
                WR_PUSH: begin
                    if (burst_take) begin
                        wr_state <= WR_ISSUE;
                    end
                end
                WR_ISSUE: begin
                    // Hold the request until the arbiter has sent it
                    if (wr_done) begin
                        wr_addr <= wr_addr + byte_addr_t'(BYTE_PER_CMD);
                        if (wr_addr == byte_addr_t'(FRAME_BYTES - BYTE_PER_CMD)) begin
                            wr_state <= WR_IDLE;
                        end else begin
                            wr_state <= WR_PUSH;
                        end
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    assign wr_req = '{req: (wr_state == WR_ISSUE), byte_addr: wr_addr};

endmodule

`default_nettype wire

//--- verilog/mif_pkg.sv
`default_nettype none

package mif_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes of the controller port 0 data path
    ////////////////////////////////////////////////////////////

    // 128-bit user data bus
    localparam int unsigned BYTE_PER_WORD = 16;
    // Words per burst command, at least 2
    localparam int unsigned BURST_LENGTH = 16;
    localparam int unsigned BYTE_PER_CMD = BYTE_PER_WORD * BURST_LENGTH;

    // UXGA at 16 bits per pixel
    localparam int unsigned UXGA_FRAME_BYTES = 1600 * 1200 * 2;

    // Vectors with a meaning of their own
    typedef logic [29:0]  byte_addr_t;
    typedef logic [127:0] pix_word_t;
    typedef logic [6:0]   burst_cnt_t;
    typedef logic [5:0]   burst_len_t;

    // Controller command codes
    typedef enum logic [2:0] {
        MCB_WRITE = 3'b000,
        MCB_READ  = 3'b001
    } mcb_instr_t;

    ////////////////////////////////////////////////////////////
    // FSM encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {WR_IDLE, WR_PUSH, WR_ISSUE} wr_state_t;

    typedef enum logic [1:0] {RD_IDLE, RD_WAIT_DATA, RD_WAIT_DRAIN, RD_ISSUE} rd_state_t;

    typedef enum logic {ISSUE_WAIT, ISSUE_ACT} issue_state_t;

    // Burst request from a channel to the arbiter
    typedef struct packed {
        logic       req;
        byte_addr_t byte_addr;
    } issue_req_t;

    // Command word on the controller port
    typedef struct packed {
        mcb_instr_t instr;
        byte_addr_t byte_addr;
    } mcb_cmd_t;

endpackage

`default_nettype wire
